// ==== dcache_trace.txt ====
# columns: rtype (0 load, 1 store) addr dtype wdata expected_load_data expect_hit
# dtype bits 1..0 are the width (0 byte, 1 half, 2 word), bit 2 marks unsigned
0 0100 2 00000000 0b080502 0
0 0104 2 00000000 1714110e 1
0 012c 0 00000000 ffffff86 1
0 012d 0 00000000 ffffff89 1
0 012e 0 00000000 ffffff8c 1
0 012f 0 00000000 ffffff8f 1
0 012c 4 00000000 00000086 1
0 012d 4 00000000 00000089 1
0 012e 4 00000000 0000008c 1
0 012f 4 00000000 0000008f 1
0 0108 0 00000000 0000001a 1
0 012c 1 00000000 ffff8986 1
0 012e 1 00000000 ffff8f8c 1
0 012c 5 00000000 00008986 1
0 012e 5 00000000 00008f8c 1
0 012d 1 00000000 00000000 1
0 012e 2 00000000 00000000 1
1 0111 0 123456a5 00000000 0
1 0112 1 5555beef 00000000 0
0 0110 2 00000000 beefa532 1
1 024a 1 00007788 00000000 0
0 0248 2 00000000 7788dedb 1
0 024c 2 00000000 f0edeae7 1
0 0310 2 00000000 3d3a3734 0
0 0110 2 00000000 beefa532 0

// ==== src.f ====
dcache_pkg.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_line_store.sv
dcache_load_align.sv
dcache_top.sv
dcache_chk.sv
tb_dcache_checker.sv
tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_dcache -f src.f --Mdir obj_dir -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam int timeout_cycles = 200;
    localparam int mem_bytes = 2 ** addr_w;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic                  req_ready;
    logic [addr_w-1:0]     req_addr;
    logic [arch_w-1:0]     req_wdata;
    dtype_t                req_dtype;
    rtype_t                req_rtype;
    logic                  rsp_valid;
    logic [arch_w-1:0]     rsp_data;
    logic                  mem_r_valid;
    logic [mem_addr_w-1:0] mem_r_addr;
    logic                  mem_rsp_valid = 1'b0;
    logic [mem_w-1:0]      mem_rsp_data = '0;
    logic                  mem_w_valid;
    logic [mem_addr_w-1:0] mem_w_addr;
    logic [mem_w-1:0]      mem_w_data;
    logic                  exp_valid;
    logic [arch_w-1:0]     exp_data;
    logic                  exp_hit;
    logic [7:0]            mem [0:mem_bytes-1];
    int                    data_errs;
    int                    proto_errs;
    int                    wr_errs;
    int                    rsp_count;
    int                    timeouts = 0;
    int                    setup_errs = 0;
    int                    loads_issued = 0;
    logic                  aborted = 1'b0;

    dcache_top #(.sets(4)) dcache_top_i (
        .clk, .rst, .req_valid, .req_ready, .req_addr, .req_wdata, .req_dtype,
        .req_rtype, .rsp_valid, .rsp_data, .mem_r_valid, .mem_r_addr,
        .mem_rsp_valid, .mem_rsp_data, .mem_w_valid, .mem_w_addr, .mem_w_data
    );

    tb_dcache_checker checker_i (
        .clk, .rst, .req_ready, .rsp_valid, .rsp_data, .mem_r_valid, .mem_r_addr,
        .mem_w_valid, .mem_w_addr, .exp_valid, .exp_data, .exp_hit,
        .data_errs, .proto_errs, .wr_errs, .rsp_count
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // byte memory, reads answer one cycle later, writes land at the strobe edge
    always @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < mem_bytes; a++) begin
                mem[a] <= 8'(3 * a + (a >> 8) + 1);
            end
            mem_rsp_valid <= 1'b0;
        end else begin
            mem_rsp_valid <= mem_r_valid;
            if (mem_r_valid) begin
                for (int i = 0; i < mem_w / 8; i++) begin
                    mem_rsp_data[i*8 +: 8] <= mem[{mem_r_addr, 4'(i)}];
                end
            end
            if (mem_w_valid) begin
                for (int i = 0; i < mem_w / 8; i++) begin
                    mem[{mem_w_addr, 4'(i)}] <= mem_w_data[i*8 +: 8];
                end
            end
        end
    end

    task automatic wait_for_ready();
        int waited;
        waited = 0;
        while ((req_ready !== 1'b1) && (waited < timeout_cycles)) begin
            @(posedge clk);
            waited++;
        end
        if (req_ready !== 1'b1) begin
            $display("timeout: req_ready did not rise after reset");
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic issue_row(input logic rt, input logic [addr_w-1:0] addr,
                             input dtype_t dt, input logic [arch_w-1:0] wd,
                             input logic [arch_w-1:0] ed, input logic eh);
        int   waited;
        logic done;
        req_valid <= 1'b1;
        req_addr  <= addr;
        req_wdata <= wd;
        req_dtype <= dt;
        req_rtype <= rtype_t'(rt);
        waited = 0;
        done   = 1'b0;
        while (!done && (waited < timeout_cycles)) begin
            @(posedge clk);
            exp_valid <= 1'b0;
            if (req_ready) begin
                done = 1'b1;
                if (rt == rt_read) begin
                    exp_valid <= 1'b1;
                    exp_data  <= ed;
                    exp_hit   <= eh;
                    loads_issued++;
                end
            end
            waited++;
        end
        if (!done) begin
            $display("timeout: request at address %h was not accepted", addr);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_trace();
        int               fd;
        int               n;
        string            line;
        logic             f_rt;
        logic [addr_w-1:0] f_addr;
        dtype_t           f_dt;
        logic [arch_w-1:0] f_wd;
        logic [arch_w-1:0] f_ed;
        logic             f_eh;
        fd = $fopen("dcache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open dcache_trace.txt");
            setup_errs++;
            aborted = 1'b1;
        end else begin
            while (!aborted && ($fgets(line, fd) > 0)) begin
                if ((line.len() > 0) && (line.getc(0) != "#")) begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                f_rt, f_addr, f_dt, f_wd, f_ed, f_eh);
                    if (n == 6) begin
                        issue_row(f_rt, f_addr, f_dt, f_wd, f_ed, f_eh);
                    end
                end
            end
            $fclose(fd);
        end
        req_valid <= 1'b0;
    endtask

    // waits until every issued load has answered and no miss is in progress
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        exp_valid <= 1'b0;
        do begin
            @(negedge clk);
            waited++;
        end while (!((rsp_count == loads_issued) && req_ready) && (waited < timeout_cycles));
        if (!((rsp_count == loads_issued) && req_ready)) begin
            $display("timeout: %0d of %0d load responses seen at end of trace",
                     rsp_count, loads_issued);
            timeouts++;
        end
    endtask

    initial begin
        int total;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_dtype = '0;
        req_rtype = rt_read;
        exp_valid = 1'b0;
        exp_data  = '0;
        exp_hit   = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        wait_for_ready();
        if (!aborted) begin
            run_trace();
        end
        if (!aborted) begin
            drain();
        end
        total = data_errs + proto_errs + wr_errs + timeouts + setup_errs;
        $display("closing counts: load %0d, protocol %0d, write %0d, timeout %0d, setup %0d",
                 data_errs, proto_errs, wr_errs, timeouts, setup_errs);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb_dcache_checker.sv ====
`timescale 1ns/1ps

module tb_dcache_checker import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_ready,
    input  logic                  rsp_valid,
    input  logic [arch_w-1:0]     rsp_data,
    input  logic                  mem_r_valid,
    input  logic [mem_addr_w-1:0] mem_r_addr,
    input  logic                  mem_w_valid,
    input  logic [mem_addr_w-1:0] mem_w_addr,
    input  logic                  exp_valid,
    input  logic [arch_w-1:0]     exp_data,
    input  logic                  exp_hit,
    output int                    data_errs,
    output int                    proto_errs,
    output int                    wr_errs,
    output int                    rsp_count
);

    logic [arch_w-1:0]     exp_q [$];
    logic [arch_w-1:0]     exp_word;
    logic                  rst_q = 1'b0;
    logic                  w_run = 1'b0;
    logic [mem_addr_w-1:0] w_next;
    logic                  r_run = 1'b0;
    logic [mem_addr_w-1:0] r_next;
    int                    n_data = 0;
    int                    n_proto = 0;
    int                    n_wr = 0;
    int                    n_rsp = 0;

    assign data_errs  = n_data;
    assign proto_errs = n_proto;
    assign wr_errs    = n_wr;
    assign rsp_count  = n_rsp;

    always @(posedge clk) begin
        rst_q <= rst;
        // the state is known to be in reset here, so every strobe must be low
        if (rst_q && (req_ready || rsp_valid || mem_r_valid || mem_w_valid)) begin
            $display("[ERROR] reset levels: req_ready %h rsp_valid %h mem_r_valid %h mem_w_valid %h",
                     req_ready, rsp_valid, mem_r_valid, mem_w_valid);
            n_proto++;
        end
        if (!rst) begin
            if (exp_valid) begin
                exp_q.push_back(exp_data);
                // a hit answers in the cycle right after acceptance
                if (exp_hit && !rsp_valid) begin
                    $display("load hit gave no response one cycle after acceptance");
                    n_proto++;
                end
            end
            if (rsp_valid) begin
                n_rsp++;
                if (exp_q.size() == 0) begin
                    $display("load response arrived with no load outstanding");
                    n_data++;
                end else begin
                    exp_word = exp_q.pop_front();
                    if (rsp_data !== exp_word) begin
                        $display("[ERROR] rsp_data expected %h got %h", exp_word, rsp_data);
                        n_data++;
                    end
                end
            end
            // writeback beats of one run go to consecutive beat addresses
            if (mem_w_valid && w_run && (mem_w_addr != w_next)) begin
                $display("[ERROR] mem_w_addr expected %h got %h", w_next, mem_w_addr);
                n_wr++;
            end
            // a run starts at the line base
            if (mem_w_valid && !w_run && (mem_w_addr[1:0] != 2'd0)) begin
                $display("[ERROR] mem_w_addr expected %h got %h",
                         {mem_w_addr[mem_addr_w-1:2], 2'b00}, mem_w_addr);
                n_wr++;
            end
            // fill beats follow the same address rule
            if (mem_r_valid && r_run && (mem_r_addr != r_next)) begin
                $display("[ERROR] mem_r_addr expected %h got %h", r_next, mem_r_addr);
                n_proto++;
            end
            if (mem_r_valid && !r_run && (mem_r_addr[1:0] != 2'd0)) begin
                $display("[ERROR] mem_r_addr expected %h got %h",
                         {mem_r_addr[mem_addr_w-1:2], 2'b00}, mem_r_addr);
                n_proto++;
            end
            // the first fill beat goes out with the last writeback beat
            if (w_run && !mem_w_valid && !r_run) begin
                $display("writeback ended without a fill beat issued alongside its last beat");
                n_proto++;
            end
            w_run  <= mem_w_valid;
            w_next <= mem_w_addr + 1'b1;
            r_run  <= mem_r_valid;
            r_next <= mem_r_addr + 1'b1;
        end
    end

endmodule

// ==== dcache_chk.sv ====
`timescale 1ns/1ps

module dcache_chk (
    input logic clk,
    input logic rst,
    input logic req_ready,
    input logic rsp_valid,
    input logic mem_r_valid,
    input logic mem_rsp_valid,
    input logic fill_en
);

    // a load response is only given while the core port is ready
    rsp_needs_ready: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> req_ready)
        else $error("rsp_valid high while req_ready is low");

    // memory read data comes exactly one cycle after its request and lands in the fill
    rsp_follows_read: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> ($past(mem_r_valid) && fill_en))
        else $error("mem_rsp_valid without a mem_r_valid one cycle earlier or outside a fill");

    ready_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(req_ready))
        else $error("req_ready is unknown after reset");

endmodule

bind dcache_top dcache_chk chk_i (
    .clk, .rst, .req_ready, .rsp_valid, .mem_r_valid, .mem_rsp_valid, .fill_en
);

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int sets = 4,
    localparam int idx_bits = $clog2(sets),
    localparam int idx_w = (sets > 1) ? idx_bits : 1,
    localparam int tag_w = (addr_w - line_off_w - idx_bits > 0) ?
                           (addr_w - line_off_w - idx_bits) : 1,
    localparam int beat_w = $clog2(beats_per_line)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [addr_w-1:0]     req_addr,
    input  logic [arch_w-1:0]     req_wdata,
    input  dtype_t                req_dtype,
    input  rtype_t                req_rtype,
    output logic                  rsp_valid,
    output logic [arch_w-1:0]     rsp_data,
    output logic                  mem_r_valid,
    output logic [mem_addr_w-1:0] mem_r_addr,
    input  logic                  mem_rsp_valid,
    input  logic [mem_w-1:0]      mem_rsp_data,
    output logic                  mem_w_valid,
    output logic [mem_addr_w-1:0] mem_w_addr,
    output logic [mem_w-1:0]      mem_w_data
);

    if ((sets < 1) || (sets > 1024) || ((sets & (sets - 1)) != 0)) begin : g_bad_sets
        $error("dcache_top: sets must be a power of two from 1 to 1024");
    end

    logic [idx_w-1:0]  look_idx;
    logic              look_hit;
    logic              line_valid;
    logic              line_dirty;
    logic [tag_w-1:0]  line_tag;
    logic              acc_q;
    logic              hit_q;
    logic              dirty_q;
    logic [addr_w-1:0] addr_q;
    logic [arch_w-1:0] wdata_q;
    dtype_t            dtype_q;
    rtype_t            rtype_q;
    logic [tag_w-1:0]  victim_tag;
    logic [beat_w-1:0] beat_sel;
    logic              fill_en;
    logic [idx_w-1:0]  fill_idx;
    logic [tag_w-1:0]  fill_tag;
    logic              store_en;
    logic [addr_w-1:0] store_addr;
    logic [arch_w-1:0] store_wdata;
    dtype_t            store_dtype;
    logic [addr_w-1:0] rd_addr;
    dtype_t            rd_dtype;
    logic [arch_w-1:0] rd_word;

    dcache_lookup #(.sets(sets)) lookup_i (
        .clk, .rst, .req_valid, .req_ready, .req_addr, .req_wdata,
        .req_dtype, .req_rtype, .line_valid, .line_dirty, .line_tag,
        .look_idx, .look_hit, .acc_q, .hit_q, .dirty_q,
        .addr_q, .wdata_q, .dtype_q, .rtype_q
    );

    dcache_ctrl #(.sets(sets)) ctrl_i (
        .clk, .rst, .req_valid, .req_addr, .req_wdata, .req_dtype, .req_rtype,
        .look_hit, .acc_q, .hit_q, .dirty_q, .addr_q, .wdata_q, .dtype_q, .rtype_q,
        .victim_tag, .mem_rsp_valid, .req_ready, .rsp_valid,
        .mem_r_valid, .mem_r_addr, .mem_w_valid, .mem_w_addr,
        .beat_sel, .fill_en, .fill_idx, .fill_tag,
        .store_en, .store_addr, .store_wdata, .store_dtype,
        .rd_addr, .rd_dtype
    );

    dcache_line_store #(.sets(sets)) line_store_i (
        .clk, .rst, .look_idx, .fill_en, .fill_idx, .fill_tag, .beat_sel,
        .mem_rsp_data, .store_en, .store_addr, .store_wdata, .store_dtype,
        .rd_addr, .line_valid, .line_dirty, .line_tag, .victim_tag,
        .mem_w_data, .rd_word
    );

    dcache_load_align load_align_i (
        .rd_word, .rd_addr, .rd_dtype, .rsp_data
    );

endmodule

// ==== dcache_load_align.sv ====
`timescale 1ns/1ps

module dcache_load_align import dcache_pkg::*; (
    input  logic [arch_w-1:0] rd_word,
    input  logic [addr_w-1:0] rd_addr,
    input  dtype_t            rd_dtype,
    output logic [arch_w-1:0] rsp_data
);

    logic [1:0]  off;
    logic [1:0]  dw;
    logic        uns;
    logic        misaligned;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign off = rd_addr[1:0];
    assign dw  = rd_dtype[1:0];
    assign uns = rd_dtype[2];

    // odd half or any offset word gives zero
    assign misaligned = ((dw == dw_half) && off[0]) ||
                        ((dw == dw_word) && (off != 2'd0));

    assign byte_sel = rd_word[{off, 3'b000} +: 8];
    assign half_sel = rd_word[{off[1], 4'b0000} +: 16];

    always_comb begin
        rsp_data = '0;
        if (!misaligned) begin
            case (dw)
                dw_byte: rsp_data = {{24{!uns && byte_sel[7]}}, byte_sel};
                dw_half: rsp_data = {{16{!uns && half_sel[15]}}, half_sel};
                dw_word: rsp_data = rd_word;
                default: rsp_data = '0;
            endcase
        end
    end

endmodule

// ==== dcache_line_store.sv ====
`timescale 1ns/1ps

module dcache_line_store import dcache_pkg::*; #(
    parameter int sets = 4,
    localparam int idx_bits = $clog2(sets),
    localparam int idx_w = (sets > 1) ? idx_bits : 1,
    localparam int tag_w = (addr_w - line_off_w - idx_bits > 0) ?
                           (addr_w - line_off_w - idx_bits) : 1,
    localparam int beat_w = $clog2(beats_per_line)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [idx_w-1:0]  look_idx,
    input  logic              fill_en,
    input  logic [idx_w-1:0]  fill_idx,
    input  logic [tag_w-1:0]  fill_tag,
    input  logic [beat_w-1:0] beat_sel,
    input  logic [mem_w-1:0]  mem_rsp_data,
    input  logic              store_en,
    input  logic [addr_w-1:0] store_addr,
    input  logic [arch_w-1:0] store_wdata,
    input  dtype_t            store_dtype,
    input  logic [addr_w-1:0] rd_addr,
    output logic              line_valid,
    output logic              line_dirty,
    output logic [tag_w-1:0]  line_tag,
    output logic [tag_w-1:0]  victim_tag,
    output logic [mem_w-1:0]  mem_w_data,
    output logic [arch_w-1:0] rd_word
);

    logic [tag_w-1:0]          tag_arr [sets];
    logic [line_bytes*8-1:0]   data_arr [sets];
    logic [sets-1:0]           valid_arr;
    logic [sets-1:0]           dirty_arr;
    logic                      fill_last;
    logic [idx_w-1:0]          st_idx;
    logic [line_off_w-3:0]     st_word;
    logic [arch_w/8-1:0]       st_mask;
    logic [arch_w-1:0]         st_data;
    logic [idx_w-1:0]          rd_idx;
    logic [line_off_w-3:0]     rd_wsel;

    assign fill_last = fill_en && (beat_sel == beat_w'(beats_per_line - 1));

    // byte lanes follow the low address bits
    assign st_idx  = idx_w'(get_idx(store_addr, sets));
    assign st_word = get_word(store_addr);
    assign st_mask = get_store_mask(store_dtype) << store_addr[1:0];
    assign st_data = store_wdata << {store_addr[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else begin
            if (fill_last) begin
                valid_arr[fill_idx] <= 1'b1;
                dirty_arr[fill_idx] <= 1'b0;
            end
            if (store_en) begin
                dirty_arr[st_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_arr[fill_idx][beat_sel*mem_w +: mem_w] <= mem_rsp_data;
        end
        if (fill_last) begin
            tag_arr[fill_idx] <= fill_tag;
        end
        if (store_en) begin
            for (int b = 0; b < arch_w/8; b++) begin
                if (st_mask[b]) begin
                    data_arr[st_idx][st_word*arch_w + b*8 +: 8] <= st_data[b*8 +: 8];
                end
            end
        end
    end

    assign line_valid = valid_arr[look_idx];
    assign line_dirty = dirty_arr[look_idx];
    assign line_tag   = tag_arr[look_idx];

    // victim side reads the set of the pending request
    assign victim_tag = tag_arr[fill_idx];
    assign mem_w_data = data_arr[fill_idx][beat_sel*mem_w +: mem_w];

    assign rd_idx  = idx_w'(get_idx(rd_addr, sets));
    assign rd_wsel = get_word(rd_addr);
    assign rd_word = data_arr[rd_idx][rd_wsel*arch_w +: arch_w];

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int sets = 4,
    localparam int idx_bits = $clog2(sets),
    localparam int idx_w = (sets > 1) ? idx_bits : 1,
    localparam int tag_w = (addr_w - line_off_w - idx_bits > 0) ?
                           (addr_w - line_off_w - idx_bits) : 1,
    localparam int beat_w = $clog2(beats_per_line)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic [addr_w-1:0]     req_addr,
    input  logic [arch_w-1:0]     req_wdata,
    input  dtype_t                req_dtype,
    input  rtype_t                req_rtype,
    input  logic                  look_hit,
    input  logic                  acc_q,
    input  logic                  hit_q,
    input  logic                  dirty_q,
    input  logic [addr_w-1:0]     addr_q,
    input  logic [arch_w-1:0]     wdata_q,
    input  dtype_t                dtype_q,
    input  rtype_t                rtype_q,
    input  logic [tag_w-1:0]      victim_tag,
    input  logic                  mem_rsp_valid,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output logic                  mem_r_valid,
    output logic [mem_addr_w-1:0] mem_r_addr,
    output logic                  mem_w_valid,
    output logic [mem_addr_w-1:0] mem_w_addr,
    output logic [beat_w-1:0]     beat_sel,
    output logic                  fill_en,
    output logic [idx_w-1:0]      fill_idx,
    output logic [tag_w-1:0]      fill_tag,
    output logic                  store_en,
    output logic [addr_w-1:0]     store_addr,
    output logic [arch_w-1:0]     store_wdata,
    output dtype_t                store_dtype,
    output logic [addr_w-1:0]     rd_addr,
    output dtype_t                rd_dtype
);

    dc_state_t         state;
    dc_state_t         state_nx;
    logic [addr_w-1:0] pend_addr;
    logic [arch_w-1:0] pend_wdata;
    dtype_t            pend_dtype;
    rtype_t            pend_rtype;
    logic              miss_seen;
    logic              acc_store_hit;
    logic              fill_last;
    logic              serve_q;
    logic              repl_q;
    logic [beat_w-1:0] w_cnt;
    logic [beat_w-1:0] f_cnt;
    logic [beat_w:0]   r_cnt;
    logic [addr_w-1:0] vic_base;

    // a registered request that missed holds the core off
    assign miss_seen = (state == dc_ready) && acc_q && !hit_q;
    assign req_ready = (state == dc_ready) && !(acc_q && !hit_q);
    assign rsp_valid = (state == dc_ready) &&
                       ((acc_q && hit_q && (rtype_q == rt_read)) || serve_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dc_reset;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            dc_reset: state_nx = dc_ready;
            dc_ready: begin
                if (miss_seen) begin
                    state_nx = dirty_q ? dc_evict : dc_miss;
                end
            end
            dc_evict: begin
                if (w_cnt == beat_w'(beats_per_line - 1)) begin
                    state_nx = dc_miss;
                end
            end
            dc_miss: begin
                // a store needs one extra cycle to merge into the new line
                if (pend_rtype == rt_write) begin
                    if (repl_q) begin
                        state_nx = dc_ready;
                    end
                end else if (fill_last) begin
                    state_nx = dc_ready;
                end
            end
            default: state_nx = dc_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (miss_seen) begin
            pend_addr  <= addr_q;
            pend_wdata <= wdata_q;
            pend_dtype <= dtype_q;
            pend_rtype <= rtype_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            serve_q <= 1'b0;
            repl_q  <= 1'b0;
            w_cnt   <= '0;
            f_cnt   <= '0;
        end else begin
            serve_q <= fill_last && (pend_rtype == rt_read);
            repl_q  <= fill_last && (pend_rtype == rt_write);
            if (mem_w_valid) begin
                w_cnt <= w_cnt + 1'b1;
            end
            if (fill_en) begin
                f_cnt <= f_cnt + 1'b1;
            end
        end
    end

    // counts issued read beats, msb set once the whole line is requested
    always_ff @(posedge clk) begin
        if (rst || (state == dc_ready)) begin
            r_cnt <= '0;
        end else if (mem_r_valid) begin
            r_cnt <= r_cnt + 1'b1;
        end
    end

    assign fill_idx = idx_w'(get_idx(pend_addr, sets));
    assign fill_tag = tag_w'(get_tag(pend_addr, idx_bits));
    assign vic_base = (addr_w'(victim_tag) << (line_off_w + idx_bits)) |
                      (addr_w'(fill_idx) << line_off_w);

    // the first read beat goes out together with the last writeback beat
    assign mem_w_valid = (state == dc_evict);
    assign mem_w_addr  = {vic_base[addr_w-1:line_off_w], w_cnt};
    assign mem_r_valid = ((state == dc_evict) && (w_cnt == beat_w'(beats_per_line - 1))) ||
                         ((state == dc_miss) && !r_cnt[beat_w]);
    assign mem_r_addr  = {pend_addr[addr_w-1:line_off_w], r_cnt[beat_w-1:0]};

    assign beat_sel  = (state == dc_evict) ? w_cnt : f_cnt;
    assign fill_en   = mem_rsp_valid && (state == dc_miss);
    assign fill_last = fill_en && (f_cnt == beat_w'(beats_per_line - 1));

    // store hits write at acceptance, a missed store is replayed after the fill
    assign acc_store_hit = req_valid && req_ready && look_hit && (req_rtype == rt_write);
    assign store_en      = acc_store_hit || repl_q;
    assign store_addr    = acc_store_hit ? req_addr : pend_addr;
    assign store_wdata   = acc_store_hit ? req_wdata : pend_wdata;
    assign store_dtype   = acc_store_hit ? req_dtype : pend_dtype;

    assign rd_addr  = serve_q ? pend_addr : addr_q;
    assign rd_dtype = serve_q ? pend_dtype : dtype_q;

endmodule

// ==== dcache_lookup.sv ====
`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; #(
    parameter int sets = 4,
    localparam int idx_bits = $clog2(sets),
    localparam int idx_w = (sets > 1) ? idx_bits : 1,
    localparam int tag_w = (addr_w - line_off_w - idx_bits > 0) ?
                           (addr_w - line_off_w - idx_bits) : 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  logic              req_ready,
    input  logic [addr_w-1:0] req_addr,
    input  logic [arch_w-1:0] req_wdata,
    input  dtype_t            req_dtype,
    input  rtype_t            req_rtype,
    input  logic              line_valid,
    input  logic              line_dirty,
    input  logic [tag_w-1:0]  line_tag,
    output logic [idx_w-1:0]  look_idx,
    output logic              look_hit,
    output logic              acc_q,
    output logic              hit_q,
    output logic              dirty_q,
    output logic [addr_w-1:0] addr_q,
    output logic [arch_w-1:0] wdata_q,
    output dtype_t            dtype_q,
    output rtype_t            rtype_q
);

    logic             acc;
    logic [tag_w-1:0] look_tag;

    assign acc = req_valid && req_ready;

    // tag compare against the set addressed by the incoming request
    assign look_idx = idx_w'(get_idx(req_addr, sets));
    assign look_tag = tag_w'(get_tag(req_addr, idx_bits));
    assign look_hit = line_valid && (line_tag == look_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= 1'b0;
        end else begin
            acc_q <= acc;
        end
    end

    // decoded request, only meaningful while acc_q is high
    always_ff @(posedge clk) begin
        if (acc) begin
            hit_q   <= look_hit;
            dirty_q <= line_dirty;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            dtype_q <= req_dtype;
            rtype_q <= req_rtype;
        end
    end

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int addr_w = 16;
    localparam int arch_w = 32;
    localparam int mem_w = 128;
    localparam int mem_addr_w = addr_w - 4;
    localparam int line_bytes = 64;
    localparam int beats_per_line = 4;
    localparam int line_off_w = 6;

    // bits 1..0 give the access width, bit 2 set means unsigned
    typedef logic [2:0] dtype_t;
    localparam logic [1:0] dw_byte = 2'd0;
    localparam logic [1:0] dw_half = 2'd1;
    localparam logic [1:0] dw_word = 2'd2;

    typedef enum logic {
        rt_read  = 1'b0,
        rt_write = 1'b1
    } rtype_t;

    typedef enum logic [1:0] {
        dc_reset = 2'd0,
        dc_ready = 2'd1,
        dc_miss  = 2'd2,
        dc_evict = 2'd3
    } dc_state_t;

    // set index, left in a full address width; callers cut it down
    function automatic logic [addr_w-1:0] get_idx(input logic [addr_w-1:0] addr,
                                                  input int sets);
        return (addr >> line_off_w) & addr_w'(sets - 1);
    endfunction

    function automatic logic [addr_w-1:0] get_tag(input logic [addr_w-1:0] addr,
                                                  input int idx_bits);
        return addr >> (line_off_w + idx_bits);
    endfunction

    // word within the line
    function automatic logic [line_off_w-3:0] get_word(input logic [addr_w-1:0] addr);
        return addr[line_off_w-1:2];
    endfunction

    function automatic logic [arch_w/8-1:0] get_store_mask(input dtype_t dtype);
        case (dtype[1:0])
            dw_byte: return 4'b0001;
            dw_half: return 4'b0011;
            dw_word: return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

endpackage
